// File: lz77_cluster_merge.f
+incdir+include
verilog/lz77_cluster_pkg.sv
verilog/lz77_match_stree.sv
verilog/lz77_phase_counter.sv
verilog/lz77_cont_fsm.sv
verilog/lz77_trunc_mask.sv
verilog/lz77_cluster_merge.sv
tests/lz77_merge_checker.sv
tests/tb_lz77_cluster_merge.sv

// File: run_sim.sh
#!/bin/sh
# build the cluster merge testbench with Verilator, run it and scan the log

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_lz77_cluster_merge \
   -f lz77_cluster_merge.f -o sim_tb > build.log 2>&1 \
   && ./obj_dir/sim_tb > sim.log 2>&1 \
   && grep -q "Everything OK" sim.log \
   && echo "simulation passed" \
   || { echo "simulation failed, see build.log and sim.log"; exit 1; }

// File: tests/tb_lz77_cluster_merge.sv
// Cluster merge testbench
`timescale 1ns/10ps
`include "lz77_cluster_config.svh"

module tb_lz77_cluster_merge;

   localparam int ROWS    = 20;
   localparam int TIMEOUT = 10;

   logic                                                         clk;
   logic                                                         clt_rst_n;
   lz77_cluster_pkg::therm_t    [`LZ_TILES-1:0][`LZ_PHASES-1:0] tile_therm;
   lz77_cluster_pkg::tile_off_t [`LZ_TILES-1:0][`LZ_PHASES-1:0] tile_offset;
   logic [`LZ_TILES-1:0][3:0]                                   tile_len4_ind;
   logic [`LZ_TILES-1:0][2:0]                                   tile_len56_ind;
   lz77_cluster_pkg::dmw_t                                      dmw_cont;
   logic [1:0]                                                  max_len_mode;
   logic [2:0]                                                  win_size;
   logic                                                        input_en;
   lz77_cluster_pkg::therm_t   [`LZ_PHASES-1:0]                 fwd_therm;
   lz77_cluster_pkg::clt_off_t [`LZ_PHASES-1:0]                 offset;
   lz77_cluster_pkg::phase_vec_t                                truncated;
   logic [3:0]                                                  len4_ind;
   logic [2:0]                                                  len56_ind;
   logic                                                        cont;

   logic                                      check;
   logic                                      report;
   lz77_cluster_pkg::therm_t [`LZ_PHASES-1:0] exp_mask;
   logic                                      exp_cont;
   int                                        error_count;

   // each row is one input step and carries what the length limit leaves of each phase
   lz77_cluster_pkg::therm_t    [`LZ_TILES-1:0][`LZ_PHASES-1:0] row_therm  [ROWS];
   lz77_cluster_pkg::tile_off_t [`LZ_TILES-1:0][`LZ_PHASES-1:0] row_offset [ROWS];
   logic [`LZ_TILES-1:0][3:0]                                   row_len4   [ROWS];
   logic [`LZ_TILES-1:0][2:0]                                   row_len56  [ROWS];
   lz77_cluster_pkg::dmw_t                                      row_dmw    [ROWS];
   logic [1:0]                                                  row_mode   [ROWS];
   logic [2:0]                                                  row_win    [ROWS];
   lz77_cluster_pkg::therm_t [`LZ_PHASES-1:0]                   row_mask   [ROWS];
   logic                                                        row_cont   [ROWS];

   lz77_cluster_merge UUT (
      .clk            (clk),
      .clt_rst_n      (clt_rst_n),
      .tile_therm     (tile_therm),
      .tile_offset    (tile_offset),
      .tile_len4_ind  (tile_len4_ind),
      .tile_len56_ind (tile_len56_ind),
      .dmw_cont       (dmw_cont),
      .max_len_mode   (max_len_mode),
      .win_size       (win_size),
      .input_en       (input_en),
      .fwd_therm      (fwd_therm),
      .offset         (offset),
      .truncated      (truncated),
      .len4_ind       (len4_ind),
      .len56_ind      (len56_ind),
      .cont           (cont)
   );

   lz77_merge_checker u_checker (
      .clk            (clk),
      .clt_rst_n      (clt_rst_n),
      .check          (check),
      .report         (report),
      .exp_mask       (exp_mask),
      .exp_cont       (exp_cont),
      .tile_therm     (tile_therm),
      .tile_offset    (tile_offset),
      .tile_len4_ind  (tile_len4_ind),
      .tile_len56_ind (tile_len56_ind),
      .fwd_therm      (fwd_therm),
      .offset         (offset),
      .truncated      (truncated),
      .len4_ind       (len4_ind),
      .len56_ind      (len56_ind),
      .cont           (cont),
      .error_count    (error_count)
   );

   always #4 clk = ~clk;

   function automatic lz77_cluster_pkg::therm_t therm_of_len(int n);
      return lz77_cluster_pkg::therm_t'((1 << n) - 1);
   endfunction

   task automatic fill_row(input int r, input int max_ones, input lz77_cluster_pkg::dmw_t dmw,
                           input logic [1:0] mode, input logic [2:0] win);
      for (int t = 0; t < `LZ_TILES; t++) begin
         for (int p = 0; p < `LZ_PHASES; p++) begin
            row_therm[r][t][p]  = therm_of_len(int'($urandom_range(max_ones, 0)));
            row_offset[r][t][p] = lz77_cluster_pkg::tile_off_t'($urandom);
         end
         row_len4[r][t]  = 4'($urandom);
         row_len56[r][t] = 3'($urandom);
      end
      row_dmw[r]  = dmw;
      row_mode[r] = mode;
      row_win[r]  = win;
      row_mask[r] = '1;
      row_cont[r] = 1'b0;
   endtask

   task automatic build_table();
      for (int r = 0; r < 8; r++) begin
         fill_row(r, 12, '0, 2'd0, 3'($urandom_range(7, 0)));
      end
      // no end-of-step matches ahead of the window code in row 9
      fill_row(8, 11, '0, 2'd0, 3'd5);
      fill_row(9, 11, 6'h20, 2'd2, 3'd5);
      // phase 3 restarts at 24 bytes against a limit of 18
      fill_row(10, 11, '0, 2'd2, 3'd5);
      row_therm[10][2][3] = therm_of_len(12);
      row_mask[10][3]     = 12'h03f;
      fill_row(11, 11, '0, 2'd0, 3'd5);
      for (int p = 0; p < `LZ_PHASES; p++) begin
         row_therm[11][1][p] = therm_of_len(12);
      end
      fill_row(12, 11, 6'h04, 2'd0, 3'd5);
      fill_row(13, 11, '0, 2'd0, 3'd5);
      row_cont[13] = 1'b1;
      fill_row(14, 11, '0, 2'd0, 3'd5);
      for (int r = 15; r < ROWS; r++) begin
         fill_row(r, 12, '0, 2'd0, 3'($urandom_range(7, 0)));
      end
   endtask

   initial begin
      int          waited;
      logic        timed_out;
      clk            = 1'b0;
      clt_rst_n      = 1'b0;
      tile_therm     = '0;
      tile_offset    = '0;
      tile_len4_ind  = '0;
      tile_len56_ind = '0;
      dmw_cont       = '0;
      max_len_mode   = 2'd0;
      win_size       = 3'd5;
      input_en       = 1'b0;
      check          = 1'b0;
      report         = 1'b0;
      exp_mask       = '1;
      exp_cont       = 1'b0;
      timed_out      = 1'b0;
      void'($urandom(32'h71ab));
      build_table();

      repeat (16) @(posedge clk);
      clt_rst_n <= 1'b1;
      repeat (4) @(posedge clk);

      for (int r = 0; r < ROWS && !timed_out; r++) begin
         @(posedge clk);
         check          <= 1'b0;
         tile_therm     <= row_therm[r];
         tile_offset    <= row_offset[r];
         tile_len4_ind  <= row_len4[r];
         tile_len56_ind <= row_len56[r];
         dmw_cont       <= row_dmw[r];
         max_len_mode   <= row_mode[r];
         win_size       <= row_win[r];
         input_en       <= 1'b1;
         @(posedge clk);
         input_en <= 1'b0;
         waited = 0;
         // step_en is looked at mid-cycle, the next rising edge is the step edge
         do begin
            @(negedge clk);
            waited++;
         end while (!UUT.step_en && waited < TIMEOUT);
         if (!UUT.step_en) begin
            $display("row %0d gave no step result within %0d cycles", r, TIMEOUT);
            timed_out = 1'b1;
         end else begin
            @(posedge clk);
            exp_mask <= row_mask[r];
            exp_cont <= row_cont[r];
            check    <= 1'b1;
         end
      end

      @(posedge clk);
      check <= 1'b0;
      @(posedge clk);
      report = 1'b1;
      #1;
      if (error_count == 0 && !timed_out) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule

// File: tests/lz77_merge_checker.sv
// Cluster merge result checker
`timescale 1ns/10ps
`include "lz77_cluster_config.svh"

module lz77_merge_checker (
   input  logic                                                        clk,
   input  logic                                                        clt_rst_n,
   input  logic                                                        check,
   input  logic                                                        report,
   input  lz77_cluster_pkg::therm_t    [`LZ_PHASES-1:0]                exp_mask,
   input  logic                                                        exp_cont,
   input  lz77_cluster_pkg::therm_t    [`LZ_TILES-1:0][`LZ_PHASES-1:0] tile_therm,
   input  lz77_cluster_pkg::tile_off_t [`LZ_TILES-1:0][`LZ_PHASES-1:0] tile_offset,
   input  logic [`LZ_TILES-1:0][3:0]                                  tile_len4_ind,
   input  logic [`LZ_TILES-1:0][2:0]                                  tile_len56_ind,
   input  lz77_cluster_pkg::therm_t   [`LZ_PHASES-1:0]                 fwd_therm,
   input  lz77_cluster_pkg::clt_off_t [`LZ_PHASES-1:0]                 offset,
   input  lz77_cluster_pkg::phase_vec_t                                truncated,
   input  logic [3:0]                                                  len4_ind,
   input  logic [2:0]                                                  len56_ind,
   input  logic                                                        cont,
   output int                                                          error_count
);

   localparam int IDX_W = $clog2(`LZ_TILES);

   int   errors    = 0;
   int   checks    = 0;
   logic rst_seen  = 1'b0;

   assign error_count = errors;

   task automatic compare(input string name, input logic [63:0] exp, input logic [63:0] got);
      checks++;
      if (exp !== got) begin
         errors++;
         $display("[FAIL] %s expected %h got %h", name, exp, got);
      end
   endtask

   // outputs are only sampled half a cycle after the edge that wrote them
   always @(negedge clk) begin
      int                       best;
      int                       best_cnt;
      int                       cnt;
      lz77_cluster_pkg::therm_t win;
      logic [3:0]               or4;
      logic [2:0]               or56;
      if (clt_rst_n && !rst_seen) begin
         rst_seen = 1'b1;
         compare("fwd_therm", 64'(0), 64'(fwd_therm));
         compare("offset", 64'(0), 64'(offset));
         compare("truncated", 64'(0), 64'(truncated));
         compare("len4_ind", 64'(0), 64'(len4_ind));
         compare("len56_ind", 64'(0), 64'(len56_ind));
         compare("cont", 64'(0), 64'(cont));
      end
      if (check) begin
         for (int p = 0; p < `LZ_PHASES; p++) begin
            best     = 0;
            best_cnt = -1;
            // most ones wins, an equal count keeps the earlier tile
            for (int t = 0; t < `LZ_TILES; t++) begin
               cnt = $countones(tile_therm[t][p]);
               if (cnt > best_cnt) begin
                  best     = t;
                  best_cnt = cnt;
               end
            end
            win = tile_therm[best][p];
            compare($sformatf("fwd_therm[%0d]", p), 64'(win & exp_mask[p]),
                    64'(fwd_therm[p]));
            compare($sformatf("offset[%0d]", p), 64'({IDX_W'(best), tile_offset[best][p]}),
                    64'(offset[p]));
            compare($sformatf("truncated[%0d]", p), 64'(|(win & ~exp_mask[p])),
                    64'(truncated[p]));
         end
         or4  = '0;
         or56 = '0;
         for (int t = 0; t < `LZ_TILES; t++) begin
            or4  = or4 | tile_len4_ind[t];
            or56 = or56 | tile_len56_ind[t];
         end
         compare("len4_ind", 64'(or4), 64'(len4_ind));
         compare("len56_ind", 64'(or56), 64'(len56_ind));
         compare("cont", 64'(exp_cont), 64'(cont));
      end
   end

   always @(posedge report) begin
      $display("checks run: %0d, errors: %0d", checks, errors);
   end

endmodule

// File: verilog/lz77_cluster_merge.sv
// LZ77 cluster match merge
`timescale 1ns/10ps
`include "lz77_cluster_config.svh"

module lz77_cluster_merge (
   input  logic                                                          clk,
   input  logic                                                          clt_rst_n,
   input  lz77_cluster_pkg::therm_t    [`LZ_TILES-1:0][`LZ_PHASES-1:0] tile_therm,
   input  lz77_cluster_pkg::tile_off_t [`LZ_TILES-1:0][`LZ_PHASES-1:0] tile_offset,
   input  logic [`LZ_TILES-1:0][3:0]                                   tile_len4_ind,
   input  logic [`LZ_TILES-1:0][2:0]                                   tile_len56_ind,
   input  lz77_cluster_pkg::dmw_t                                      dmw_cont,
   input  logic [1:0]                                                  max_len_mode,
   input  logic [2:0]                                                  win_size,
   input  logic                                                        input_en,
   output lz77_cluster_pkg::therm_t   [`LZ_PHASES-1:0]                 fwd_therm,
   output lz77_cluster_pkg::clt_off_t [`LZ_PHASES-1:0]                 offset,
   output lz77_cluster_pkg::phase_vec_t                                truncated,
   output logic [3:0]                                                  len4_ind,
   output logic [2:0]                                                  len56_ind,
   output logic                                                        cont
);

   lz77_cluster_pkg::therm_t     [`LZ_PHASES-1:0][`LZ_TILES-1:0] tree_therm;
   lz77_cluster_pkg::tile_off_t  [`LZ_PHASES-1:0][`LZ_TILES-1:0] tree_off;
   lz77_cluster_pkg::therm_t     [`LZ_PHASES-1:0]                merged_therm;
   lz77_cluster_pkg::clt_off_t   [`LZ_PHASES-1:0]                merged_offset;
   lz77_cluster_pkg::match_len_t                                 max_len;
   lz77_cluster_pkg::match_len_t [`LZ_PHASES-1:0]                phase_len;
   lz77_cluster_pkg::dmw_t                                       dmw_r;
   logic                                                         force_done;
   logic                                                         step_en;
   logic                                                         cont_run;

   // tiles report per phase, each tree wants one phase across all tiles
   for (genvar p = 0; p < `LZ_PHASES; p++) begin : g_phase
      for (genvar t = 0; t < `LZ_TILES; t++) begin : g_tile
         assign tree_therm[p][t] = tile_therm[t][p];
         assign tree_off[p][t]   = tile_offset[t][p];
      end

      lz77_match_stree u_stree (
         .therm_in   (tree_therm[p]),
         .offset_in  (tree_off[p]),
         .therm_out  (merged_therm[p]),
         .offset_out (merged_offset[p])
      );
   end

   lz77_phase_counter u_counter (
      .clk          (clk),
      .clt_rst_n    (clt_rst_n),
      .step_en      (step_en),
      .cont_run     (cont_run),
      .max_len_mode (max_len_mode),
      .win_size     (win_size),
      .dmw_r        (dmw_r),
      .max_len      (max_len),
      .phase_len    (phase_len),
      .force_done   (force_done)
   );

   lz77_cont_fsm u_fsm (
      .clk          (clk),
      .clt_rst_n    (clt_rst_n),
      .input_en     (input_en),
      .dmw_cont     (dmw_cont),
      .merged_therm (merged_therm),
      .force_done   (force_done),
      .step_en      (step_en),
      .cont_run     (cont_run),
      .dmw_r        (dmw_r),
      .cont         (cont)
   );

   lz77_trunc_mask u_mask (
      .clk            (clk),
      .clt_rst_n      (clt_rst_n),
      .step_en        (step_en),
      .max_len        (max_len),
      .phase_len      (phase_len),
      .merged_therm   (merged_therm),
      .merged_offset  (merged_offset),
      .tile_len4_ind  (tile_len4_ind),
      .tile_len56_ind (tile_len56_ind),
      .fwd_therm      (fwd_therm),
      .offset         (offset),
      .truncated      (truncated),
      .len4_ind       (len4_ind),
      .len56_ind      (len56_ind)
   );

endmodule

// File: verilog/lz77_trunc_mask.sv
// Length mask and result registers
`timescale 1ns/10ps
`include "lz77_cluster_config.svh"

module lz77_trunc_mask (
   input  logic                                          clk,
   input  logic                                          clt_rst_n,
   input  logic                                          step_en,
   input  lz77_cluster_pkg::match_len_t                  max_len,
   input  lz77_cluster_pkg::match_len_t [`LZ_PHASES-1:0] phase_len,
   input  lz77_cluster_pkg::therm_t     [`LZ_PHASES-1:0] merged_therm,
   input  lz77_cluster_pkg::clt_off_t   [`LZ_PHASES-1:0] merged_offset,
   input  logic [`LZ_TILES-1:0][3:0]                     tile_len4_ind,
   input  logic [`LZ_TILES-1:0][2:0]                     tile_len56_ind,
   output lz77_cluster_pkg::therm_t     [`LZ_PHASES-1:0] fwd_therm,
   output lz77_cluster_pkg::clt_off_t   [`LZ_PHASES-1:0] offset,
   output lz77_cluster_pkg::phase_vec_t                  truncated,
   output logic [3:0]                                    len4_ind,
   output logic [2:0]                                    len56_ind
);

   localparam int THERM_W = $bits(lz77_cluster_pkg::therm_t);

   // how many top thermometer bits each phase can reach past the limit
   localparam int MASK_DEPTH [4] = '{8, 8, 9, 10};

   lz77_cluster_pkg::therm_t [`LZ_PHASES-1:0] mask;
   logic [3:0]                                len4_or;
   logic [2:0]                                len56_or;

   always_comb begin
      lz77_cluster_pkg::match_len_t lim;
      lim = '0;
      for (int p = 0; p < `LZ_PHASES; p++) begin
         mask[p] = '1;
         if (phase_len[p] != '0) begin
            for (int i = 0; i < THERM_W; i++) begin
               if (i < MASK_DEPTH[p]) begin
                  lim = phase_len[p] - lz77_cluster_pkg::match_len_t'(i);
                  mask[p][THERM_W-1-i] = max_len >= lim;
               end
            end
         end
      end
   end

   always_comb begin
      len4_or  = '0;
      len56_or = '0;
      for (int t = 0; t < `LZ_TILES; t++) begin
         len4_or  = len4_or | tile_len4_ind[t];
         len56_or = len56_or | tile_len56_ind[t];
      end
   end

   always_ff @(posedge clk or negedge clt_rst_n) begin
      if (!clt_rst_n) begin
         fwd_therm <= '0;
         offset    <= '0;
         truncated <= '0;
         len4_ind  <= '0;
         len56_ind <= '0;
      end else if (step_en) begin
         for (int p = 0; p < `LZ_PHASES; p++) begin
            fwd_therm[p] <= merged_therm[p] & mask[p];
            truncated[p] <= |(merged_therm[p] & ~mask[p]);
         end
         offset    <= merged_offset;
         len4_ind  <= len4_or;
         len56_ind <= len56_or;
      end
   end

endmodule

// File: verilog/lz77_cont_fsm.sv
// Continuation tracking across steps
`timescale 1ns/10ps
`include "lz77_cluster_config.svh"

module lz77_cont_fsm (
   input  logic                                      clk,
   input  logic                                      clt_rst_n,
   input  logic                                      input_en,
   input  lz77_cluster_pkg::dmw_t                    dmw_cont,
   input  lz77_cluster_pkg::therm_t [`LZ_PHASES-1:0] merged_therm,
   input  logic                                      force_done,
   output logic                                      step_en,
   output logic                                      cont_run,
   output lz77_cluster_pkg::dmw_t                    dmw_r,
   output logic                                      cont
);

   localparam int THERM_W = $bits(lz77_cluster_pkg::therm_t);

   logic [2:0]                   en_dly;
   lz77_cluster_pkg::phase_vec_t top_bits;
   lz77_cluster_pkg::phase_vec_t phase_r;
   lz77_cluster_pkg::phase_vec_t phase_2r;
   lz77_cluster_pkg::phase_vec_t valid_r;
   lz77_cluster_pkg::dmw_t       hist;
   logic                         dmw_hit;

   // the tiles take three cycles from input_en to a match result
   assign step_en = en_dly[2];

   for (genvar p = 0; p < `LZ_PHASES; p++) begin : g_top
      assign top_bits[p] = merged_therm[p][THERM_W-1];
   end

   // two steps of end-of-step matches, lined up against the window code
   assign hist    = {phase_2r, phase_r[3:2]};
   assign dmw_hit = (dmw_r != '0) && ((hist > dmw_r) || ((hist & dmw_r) != '0));

   // the ongoing phases are the last step's top bits, held in phase_r
   assign cont_run = cont && ((valid_r & phase_r) != '0);

   always_ff @(posedge clk or negedge clt_rst_n) begin
      if (!clt_rst_n) begin
         en_dly   <= '0;
         phase_r  <= '0;
         phase_2r <= '0;
         valid_r  <= '0;
         dmw_r    <= '0;
         cont     <= 1'b0;
      end else begin
         en_dly <= {en_dly[1:0], input_en};
         if (step_en) begin
            phase_r  <= top_bits;
            phase_2r <= phase_r;
            dmw_r    <= dmw_cont;
            cont     <= dmw_hit || (cont_run && !force_done);
            if (dmw_r != '0) begin
               if (hist > dmw_r) begin
                  valid_r <= lz77_cluster_pkg::fold_dmw(dmw_r);
               end else begin
                  valid_r <= lz77_cluster_pkg::fold_dmw(hist & dmw_r);
               end
            end
         end
      end
   end

   // no step can leave the delay line before it has filled once
   a_no_early_step: assert property (@(posedge clk)
      $rose(clt_rst_n) |-> !step_en [*3]);

endmodule

// File: verilog/lz77_phase_counter.sv
// Match length tracking per phase
`timescale 1ns/10ps
`include "lz77_cluster_config.svh"

module lz77_phase_counter (
   input  logic                                         clk,
   input  logic                                         clt_rst_n,
   input  logic                                         step_en,
   input  logic                                         cont_run,
   input  logic [1:0]                                   max_len_mode,
   input  logic [2:0]                                   win_size,
   input  lz77_cluster_pkg::dmw_t                       dmw_r,
   output lz77_cluster_pkg::match_len_t                 max_len,
   output lz77_cluster_pkg::match_len_t [`LZ_PHASES-1:0] phase_len,
   output logic                                         force_done
);

   lz77_cluster_pkg::match_len_t [`LZ_PHASES-1:0] count_r;
   lz77_cluster_pkg::match_len_t [`LZ_PHASES-1:0] seed;
   lz77_cluster_pkg::dmw_t                        win_r;
   lz77_cluster_pkg::dmw_t                        win;
   lz77_cluster_pkg::phase_vec_t                  seeded;
   lz77_cluster_pkg::phase_vec_t                  in_win;
   lz77_cluster_pkg::phase_vec_t                  too_long;

   // a deferred match starts this many bytes back, by phase and word
   always_comb begin
      seed[3] = dmw_r[5] ? lz77_cluster_pkg::match_len_t'(24) :
                dmw_r[1] ? lz77_cluster_pkg::match_len_t'(20) : '0;
      seed[2] = dmw_r[4] ? lz77_cluster_pkg::match_len_t'(23) :
                dmw_r[0] ? lz77_cluster_pkg::match_len_t'(19) : '0;
      seed[1] = dmw_r[3] ? lz77_cluster_pkg::match_len_t'(22) : '0;
      seed[0] = dmw_r[2] ? lz77_cluster_pkg::match_len_t'(21) : '0;
   end

   assign seeded = lz77_cluster_pkg::fold_dmw(dmw_r);
   assign win    = (dmw_r != '0) ? dmw_r : win_r;
   assign in_win = lz77_cluster_pkg::fold_dmw(win);

   for (genvar p = 0; p < `LZ_PHASES; p++) begin : g_phase
      assign phase_len[p] = (dmw_r != '0) ? seed[p] : count_r[p];
      assign too_long[p]  = max_len < phase_len[p];

      // a running count keeps the byte alignment its seed gave it
      a_count_align: assert property (@(posedge clk) disable iff (!clt_rst_n)
         (count_r[p] == '0) || (count_r[p][1:0] == 2'(p + 1)));
   end

   // nothing left to follow once every windowed phase has passed the limit
   assign force_done = &(too_long | ~in_win);

   always_ff @(posedge clk or negedge clt_rst_n) begin
      if (!clt_rst_n) begin
         max_len <= '0;
         count_r <= '0;
         win_r   <= '0;
      end else begin
         case (max_len_mode)
            2'd1: max_len <= 17'h00102;
            2'd2: max_len <= 17'h00012;
            2'd3: max_len <= 17'h00040;
            default: begin
               case (win_size)
                  3'd0:    max_len <= 17'h00200;
                  3'd1:    max_len <= 17'h01000;
                  3'd2:    max_len <= 17'h02000;
                  3'd3:    max_len <= 17'h04000;
                  3'd4:    max_len <= 17'h08000;
                  default: max_len <= 17'h0ffff;
               endcase
            end
         endcase

         if (step_en) begin
            win_r <= win;
            for (int p = 0; p < `LZ_PHASES; p++) begin
               if (seeded[p]) begin
                  count_r[p] <= seed[p] + 4'd4;
               end else if (count_r[p] != '0 && !force_done && cont_run) begin
                  count_r[p] <= count_r[p] + 4'd4;
               end else begin
                  count_r[p] <= '0;
               end
            end
         end
      end
   end

endmodule

// File: verilog/lz77_match_stree.sv
// Longest match selection tree
`timescale 1ns/10ps
`include "lz77_cluster_config.svh"

module lz77_match_stree (
   input  lz77_cluster_pkg::therm_t    [`LZ_TILES-1:0] therm_in,
   input  lz77_cluster_pkg::tile_off_t [`LZ_TILES-1:0] offset_in,
   output lz77_cluster_pkg::therm_t                    therm_out,
   output lz77_cluster_pkg::clt_off_t                  offset_out
);

   localparam int TILE_IDX_W = $clog2(`LZ_TILES);
   localparam int NODES      = 2 * `LZ_TILES - 1;

   // node n has children 2n+1 and 2n+2 in heap order and the leaves hold the tiles
   lz77_cluster_pkg::therm_t   [NODES-1:0] node_therm;
   lz77_cluster_pkg::clt_off_t [NODES-1:0] node_off;

   for (genvar t = 0; t < `LZ_TILES; t++) begin : g_leaf
      assign node_therm[`LZ_TILES-1+t] = therm_in[t];
      assign node_off[`LZ_TILES-1+t]   = {TILE_IDX_W'(t), offset_in[t]};

      // the tiles must deliver clean thermometers or the compare below is wrong
      always_comb begin
         if (!$isunknown(therm_in[t])) begin
            a_therm_form: assert ((therm_in[t] & (therm_in[t] + 1'b1)) == '0)
               else $error("tile %0d thermometer %h is not ones then zeros",
                           t, therm_in[t]);
         end
      end
   end

   for (genvar n = 0; n < `LZ_TILES - 1; n++) begin : g_node
      logic take_hi;

      // thermometer codes order the same way as their one counts
      // the upper child must be strictly longer, so ties stay with the lower tile
      assign take_hi       = node_therm[2*n+2] > node_therm[2*n+1];
      assign node_therm[n] = take_hi ? node_therm[2*n+2] : node_therm[2*n+1];
      assign node_off[n]   = take_hi ? node_off[2*n+2]   : node_off[2*n+1];
   end

   assign therm_out  = node_therm[0];
   assign offset_out = node_off[0];

endmodule

// File: verilog/lz77_cluster_pkg.sv
// LZ77 cluster merge types
`include "lz77_cluster_config.svh"

package lz77_cluster_pkg;

   // more ones means a longer match, the top bit runs to the end of the step
   typedef logic [`LZ_THERM_W-1:0] therm_t;

   typedef logic [`LZ_TILE_OFF_W-1:0] tile_off_t;

   // tile index in the upper bits, tile offset below
   typedef logic [$clog2(`LZ_TILES)+`LZ_TILE_OFF_W-1:0] clt_off_t;

   typedef logic [`LZ_LEN_W-1:0] match_len_t;

   // bits 5..2 are phases 3..0, bits 1..0 alias phases 3 and 2 in the second word
   typedef logic [`LZ_DMW_W-1:0] dmw_t;

   typedef logic [`LZ_PHASES-1:0] phase_vec_t;

   // map a window code onto the phases it touches
   function automatic phase_vec_t fold_dmw(dmw_t code);
      return code[5:2] | {code[1:0], 2'b00};
   endfunction

endpackage

// File: include/lz77_cluster_config.svh
// LZ77 cluster merge configuration
`ifndef LZ77_CLUSTER_CONFIG_SVH
`define LZ77_CLUSTER_CONFIG_SVH

// tiles per cluster
`define LZ_TILES 4

// byte phases per input step
`define LZ_PHASES 4

// forward match thermometer width
`define LZ_THERM_W 12

// offset inside one tile
`define LZ_TILE_OFF_W 4

// match length counters
`define LZ_LEN_W 17

// deferred-match-window code
`define LZ_DMW_W 6

`endif
